// ==== files.f ====
+incdir+common
common/div_pkg.sv
div_unit/div_radix4_step.sv
div_unit/div_operand_prep.sv
div_unit/div_lane.sv
div_unit/div_unit.sv
tests/div_unit_assertions.sv
tests/tb_div_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_div_unit -o tb_div_unit
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_div_unit 2>&1)
status=$?
printf '%s\n' "$output"

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "Pass message not found"
exit 1

// ==== tests/tb_div_unit.sv ====
// Directed testbench for div_unit that stops at the first mismatch; expected values are hand computed
module tb_div_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import div_pkg::*;

    // One table row
    typedef struct packed {
        logic  lane;
        logic  op_32;
        logic  sgn;
        logic  rem;
        xlen_t dividend;
        xlen_t divisor;
        tag_t  tag;
        xlen_t expected;
    } vector_t;

    logic  clk_i;
    logic  rstn_i;
    logic  flush_i;
    logic  start_i;
    logic  lane_sel_i;
    logic  op_32_i;
    logic  signed_op_i;
    logic  rem_op_i;
    xlen_t dividend_i;
    xlen_t divisor_i;
    tag_t  tag_i;
    logic  valid_o;
    xlen_t result_o;
    tag_t  tag_o;

    int      cycle_cnt;     // Edges since reset release
    vector_t vectors[$];

    div_unit dut_i (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .flush_i     (flush_i),
        .start_i     (start_i),
        .lane_sel_i  (lane_sel_i),
        .op_32_i     (op_32_i),
        .signed_op_i (signed_op_i),
        .rem_op_i    (rem_op_i),
        .dividend_i  (dividend_i),
        .divisor_i   (divisor_i),
        .tag_i       (tag_i),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .tag_o       (tag_o)
    );

    bind div_unit div_unit_assertions asserts_i (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .flush_i (flush_i),
        .valid_o (valid_o)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ctl packs {lane, op_32, signed, rem}
    function automatic vector_t make_vector(input logic [3:0] ctl, input xlen_t dividend,
                                            input xlen_t divisor, input tag_t tag,
                                            input xlen_t expected);
        vector_t v;
        {v.lane, v.op_32, v.sgn, v.rem} = ctl;
        v.dividend = dividend;
        v.divisor  = divisor;
        v.tag      = tag;
        v.expected = expected;
        return v;
    endfunction

    task automatic add_vector(input logic [3:0] ctl, input xlen_t dividend,
                              input xlen_t divisor, input tag_t tag, input xlen_t expected);
        vectors.push_back(make_vector(ctl, dividend, divisor, tag, expected));
    endtask

    task automatic issue_op(input vector_t v, output int accept_cycle);
        @(posedge clk_i);
        #2;
        start_i     = 1'b1;
        lane_sel_i  = v.lane;
        op_32_i     = v.op_32;
        signed_op_i = v.sgn;
        rem_op_i    = v.rem;
        dividend_i  = v.dividend;
        divisor_i   = v.divisor;
        tag_i       = v.tag;
        @(posedge clk_i);                  // Accepted here
        #2;
        start_i      = 1'b0;
        accept_cycle = cycle_cnt;
    endtask

    task automatic wait_result(input int limit, output int seen_cycle);
        int   waited;
        logic found;
        waited = 0;
        found  = 1'b0;
        while (!found && waited < limit) begin
            @(negedge clk_i);
            if (valid_o === 1'b1) begin
                found = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!found) begin
            $display("Timeout: no valid_o pulse within %0d cycles", limit);
            $display("*** FAILED ***");
            $fatal(1, "Result never arrived");
        end else begin
            seen_cycle = cycle_cnt;
        end
    endtask

    task automatic check_result(input vector_t v, input int accept, input int seen);
        int lat_exp;
        lat_exp = v.op_32 ? 16 : 32;       // Word forms run half the steps
        check_value("latency", 64'(seen - accept), 64'(lat_exp));
        check_value("result_o", result_o, v.expected);
        check_value("tag_o", 64'(tag_o), 64'(v.tag));
    endtask

    task automatic run_vector(input vector_t v);
        int accept;
        int seen;
        issue_op(v, accept);
        wait_result(40, seen);
        check_result(v, accept, seen);
        @(negedge clk_i);
        check_value("valid_o", 64'(valid_o), 64'h0);   // Pulse lasts one cycle
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        vector_t first;
        vector_t second;
        int      accept0;
        int      accept1;
        int      seen;

        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        flush_i     = 1'b0;
        start_i     = 1'b0;
        lane_sel_i  = 1'b0;
        op_32_i     = 1'b0;
        signed_op_i = 1'b0;
        rem_op_i    = 1'b0;
        dividend_i  = '0;
        divisor_i   = '0;
        tag_i       = '0;

        // 64-bit signed and unsigned with truncation
        add_vector(4'b0010, 64'hFFFF_FFFF_FFFF_FF9C, 64'h7, 5'd1, 64'hFFFF_FFFF_FFFF_FFF2);
        add_vector(4'b1011, 64'hFFFF_FFFF_FFFF_FF9C, 64'h7, 5'd2, 64'hFFFF_FFFF_FFFF_FFFE);
        add_vector(4'b0010, 64'h64, 64'hFFFF_FFFF_FFFF_FFF9, 5'd3, 64'hFFFF_FFFF_FFFF_FFF2);
        add_vector(4'b1011, 64'h64, 64'hFFFF_FFFF_FFFF_FFF9, 5'd4, 64'h2);
        add_vector(4'b0010, 64'hFFFF_FFFF_FFFF_FF9C, 64'hFFFF_FFFF_FFFF_FFF9, 5'd5, 64'hE);
        add_vector(4'b1011, 64'hFFFF_FFFF_FFFF_FF9C, 64'hFFFF_FFFF_FFFF_FFF9, 5'd6,
                   64'hFFFF_FFFF_FFFF_FFFE);
        add_vector(4'b0000, 64'h8000_0000_0000_0000, 64'h3, 5'd7, 64'h2AAA_AAAA_AAAA_AAAA);
        add_vector(4'b1001, 64'h8000_0000_0000_0000, 64'h3, 5'd8, 64'h2);
        add_vector(4'b0010, 64'h8000_0000_0000_0000, 64'h3, 5'd9, 64'hD555_5555_5555_5556);
        add_vector(4'b1011, 64'h8000_0000_0000_0000, 64'h3, 5'd10, 64'hFFFF_FFFF_FFFF_FFFE);
        add_vector(4'b0001, 64'hFFFF_FFFF_FFFF_FFFE, 64'hFFFF_FFFF_FFFF_FFFF, 5'd11,
                   64'hFFFF_FFFF_FFFF_FFFE);                // Divisor above 2^63
        add_vector(4'b1000, 64'hFFFF_FFFF_FFFF_FFFF, 64'h10, 5'd12, 64'h0FFF_FFFF_FFFF_FFFF);
        // Word forms with junk in the upper halves
        add_vector(4'b0110, 64'h1234_5678_FFFF_FF9C, 64'hDEAD_BEEF_0000_0007, 5'd13,
                   64'hFFFF_FFFF_FFFF_FFF2);
        add_vector(4'b1111, 64'h1234_5678_FFFF_FF9C, 64'hDEAD_BEEF_0000_0007, 5'd14,
                   64'hFFFF_FFFF_FFFF_FFFE);
        add_vector(4'b0100, 64'hAAAA_0000_FFFF_FFFF, 64'h5555_0000_0000_0002, 5'd15,
                   64'h0000_0000_7FFF_FFFF);
        add_vector(4'b1100, 64'h0000_0001_FFFF_FFFE, 64'hFFFF_FFFF_0000_0001, 5'd16,
                   64'hFFFF_FFFF_FFFF_FFFE);                // Unsigned word still extends
        add_vector(4'b0101, 64'h1111_1111_8000_0005, 64'h10, 5'd17, 64'h5);
        // Divide by zero
        add_vector(4'b1010, 64'h1234, 64'h0, 5'd18, 64'hFFFF_FFFF_FFFF_FFFF);
        add_vector(4'b0011, 64'hFFFF_FFFF_FFFF_FF9C, 64'h0, 5'd19, 64'hFFFF_FFFF_FFFF_FF9C);
        add_vector(4'b1101, 64'h0000_0000_8000_0001, 64'hFFFF_FFFF_0000_0000, 5'd20,
                   64'hFFFF_FFFF_8000_0001);
        add_vector(4'b0110, 64'h5, 64'h7777_7777_0000_0000, 5'd21, 64'hFFFF_FFFF_FFFF_FFFF);
        // Signed overflow
        add_vector(4'b1010, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 5'd22,
                   64'h8000_0000_0000_0000);
        add_vector(4'b0011, 64'h8000_0000_0000_0000, 64'hFFFF_FFFF_FFFF_FFFF, 5'd23, 64'h0);
        add_vector(4'b1110, 64'h8000_0000, 64'hFFFF_FFFF, 5'd24, 64'hFFFF_FFFF_8000_0000);
        add_vector(4'b0111, 64'h8000_0000, 64'hFFFF_FFFF, 5'd25, 64'h0);

        repeat (2) @(posedge clk_i);
        #2;
        rstn_i = 1'b1;

        repeat (3) begin
            @(negedge clk_i);
            check_value("valid_o", 64'(valid_o), 64'h0);    // Quiet until first result
        end

        foreach (vectors[i]) begin
            run_vector(vectors[i]);
        end

        // ------------------------------------------------------------------
        // Word op on lane 1 overtakes a 64-bit op on lane 0
        // ------------------------------------------------------------------
        first  = make_vector(4'b0010, 64'hFFFF_FFFF_FFFF_FF9C, 64'h7, 5'd26,
                             64'hFFFF_FFFF_FFFF_FFF2);
        second = make_vector(4'b1100, 64'hAAAA_0000_FFFF_FFFF, 64'h5555_0000_0000_0002, 5'd27,
                             64'h0000_0000_7FFF_FFFF);
        issue_op(first, accept0);
        repeat (3) @(posedge clk_i);
        issue_op(second, accept1);
        wait_result(40, seen);
        check_result(second, accept1, seen);
        wait_result(40, seen);
        check_result(first, accept0, seen);

        // ------------------------------------------------------------------
        // Flush with both lanes busy
        // ------------------------------------------------------------------
        first  = make_vector(4'b0000, 64'h8000_0000_0000_0000, 64'h3, 5'd28,
                             64'h2AAA_AAAA_AAAA_AAAA);
        second = make_vector(4'b1011, 64'h64, 64'hFFFF_FFFF_FFFF_FFF9, 5'd29, 64'h2);
        issue_op(first, accept0);
        issue_op(second, accept1);
        repeat (29) @(posedge clk_i);
        #2;
        flush_i = 1'b1;
        @(posedge clk_i);                  // Lane 0 would finish at this edge
        #2;
        flush_i = 1'b0;
        for (int n = 0; n < 40; n++) begin
            @(negedge clk_i);
            check_value("valid_o", 64'(valid_o), 64'h0);
        end
        run_vector(make_vector(4'b0011, 64'hFFFF_FFFF_FFFF_FF9C, 64'h7, 5'd30,
                               64'hFFFF_FFFF_FFFF_FFFE));

        if (dut_i.asserts_i.fail_cnt == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "Assertion failures: %0d", dut_i.asserts_i.fail_cnt);
        end
    end

endmodule

// ==== tests/div_unit_assertions.sv ====
// Watches valid_o of div_unit only; fail_cnt holds the number of assertion failures seen
module div_unit_assertions (
    input logic clk_i,
    input logic rstn_i,
    input logic flush_i,
    input logic valid_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt;

    initial fail_cnt = 0;

    // ----------------------------------------------------------------------
    // Result pulse rules
    // ----------------------------------------------------------------------
    valid_in_reset: assert property (@(posedge clk_i) !rstn_i |-> !valid_o)
        else begin
            fail_cnt++;
            $error("valid_o high while reset is asserted");
        end

    // Flush empties both lanes at the edge
    valid_after_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
                                        flush_i |=> !valid_o)
        else begin
            fail_cnt++;
            $error("valid_o high in the cycle after a flush");
        end

    valid_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
                                  !$isunknown(valid_o))
        else begin
            fail_cnt++;
            $error("valid_o unknown after reset");  // X or Z from a lane
        end

endmodule

// ==== div_unit/div_unit.sv ====
// Two-lane divider without handshake; issuer must avoid busy lanes and same-cycle completions
`include "div_cfg.svh"

module div_unit (
    input  logic          clk_i,
    input  logic          rstn_i,
    input  logic          flush_i,      // Kills both lanes at the next edge
    input  logic          start_i,      // New operation strobe
    input  logic          lane_sel_i,   // 0 picks lane 0, 1 picks lane 1
    input  logic          op_32_i,
    input  logic          signed_op_i,
    input  logic          rem_op_i,
    input  div_pkg::xlen_t dividend_i,
    input  div_pkg::xlen_t divisor_i,
    input  div_pkg::tag_t  tag_i,
    output logic          valid_o,
    output div_pkg::xlen_t result_o,
    output div_pkg::tag_t  tag_o
);

    import div_pkg::*;

    // Prepared operands, shared by both lanes
    xlen_t dividend_mag;
    xlen_t divisor_mag;
    logic  div_zero;
    logic  same_sign;
    cnt_t  start_cnt;

    // Lane outputs
    logic  load0, load1;
    logic  done0, done1;
    xlen_t result0, result1;
    tag_t  tag0, tag1;

    div_operand_prep prep_i (
        .op_32_i        (op_32_i),
        .signed_op_i    (signed_op_i),
        .dividend_i     (dividend_i),
        .divisor_i      (divisor_i),
        .dividend_mag_o (dividend_mag),
        .divisor_mag_o  (divisor_mag),
        .div_zero_o     (div_zero),
        .same_sign_o    (same_sign),
        .start_cnt_o    (start_cnt)
    );

    // ------------------------------------------------------------------
    // Lanes
    // ------------------------------------------------------------------
    assign load0 = start_i & ~lane_sel_i;
    assign load1 = start_i &  lane_sel_i;

    div_lane lane0_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .load_i         (load0),
        .op_32_i        (op_32_i),
        .signed_op_i    (signed_op_i),
        .rem_op_i       (rem_op_i),
        .div_zero_i     (div_zero),
        .same_sign_i    (same_sign),
        .dividend_i     (dividend_i),
        .dividend_mag_i (dividend_mag),
        .divisor_mag_i  (divisor_mag),
        .start_cnt_i    (start_cnt),
        .tag_i          (tag_i),
        .done_o         (done0),
        .result_o       (result0),
        .tag_o          (tag0)
    );

    div_lane lane1_i (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .load_i         (load1),
        .op_32_i        (op_32_i),
        .signed_op_i    (signed_op_i),
        .rem_op_i       (rem_op_i),
        .div_zero_i     (div_zero),
        .same_sign_i    (same_sign),
        .dividend_i     (dividend_i),
        .dividend_mag_i (dividend_mag),
        .divisor_mag_i  (divisor_mag),
        .start_cnt_i    (start_cnt),
        .tag_i          (tag_i),
        .done_o         (done1),
        .result_o       (result1),
        .tag_o          (tag1)
    );

    // ------------------------------------------------------------------
    // Result select, lane 0 wins a tie and lane 1 is dropped
    // ------------------------------------------------------------------
    always_comb begin
        valid_o  = 1'b0;
        result_o = '0;
        tag_o    = '0;
        if (done0) begin
            valid_o  = 1'b1;
            result_o = result0;
            tag_o    = tag0;
        end else if (done1) begin
            valid_o  = 1'b1;
            result_o = result1;
            tag_o    = tag1;
        end
    end

endmodule

// ==== div_unit/div_lane.sv ====
// One divider lane; loading a busy lane overwrites its work, and flush takes priority over load
`include "div_cfg.svh"

module div_lane (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  logic           flush_i,
    input  logic           load_i,        // Accept prepared operands at this edge
    input  logic           op_32_i,
    input  logic           signed_op_i,
    input  logic           rem_op_i,
    input  logic           div_zero_i,
    input  logic           same_sign_i,
    input  div_pkg::xlen_t dividend_i,    // Raw dividend, kept for sign and zero divisor
    input  div_pkg::xlen_t dividend_mag_i,
    input  div_pkg::xlen_t divisor_mag_i,
    input  div_pkg::cnt_t  start_cnt_i,
    input  div_pkg::tag_t  tag_i,
    output logic           done_o,
    output div_pkg::xlen_t result_o,
    output div_pkg::tag_t  tag_o
);

    import div_pkg::*;

    // Control state
    cnt_t  cnt_q;
    logic  op_32_q;
    logic  signed_q;
    logic  rem_op_q;
    logic  div_zero_q;
    logic  same_sign_q;

    // Payload
    xlen_t rem_q;
    xlen_t quo_q;
    xlen_t divisor_q;
    xlen_t dividend_q;
    tag_t  tag_q;

    // Step outputs and final correction
    xlen_t rem_next;
    xlen_t quo_next;
    logic  stepping;
    logic  dividend_neg;
    xlen_t quo_final;
    xlen_t rem_final;
    xlen_t sel;
    word_t sel_word;

    // ------------------------------------------------------------------
    // Iteration
    // ------------------------------------------------------------------
    div_radix4_step step_i (
        .remainder_i (rem_q),
        .quotient_i  (quo_q),
        .divisor_i   (divisor_q),
        .remainder_o (rem_next),
        .quotient_o  (quo_next)
    );

    // Last step lands as the counter reaches one
    assign stepping = (cnt_q > cnt_t'(1));

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q       <= '0;
            op_32_q     <= 1'b0;
            signed_q    <= 1'b0;
            rem_op_q    <= 1'b0;
            div_zero_q  <= 1'b0;
            same_sign_q <= 1'b0;
        end else if (flush_i) begin
            cnt_q <= '0;                        // Lane goes idle, no result
        end else if (load_i) begin
            cnt_q       <= start_cnt_i;
            op_32_q     <= op_32_i;
            signed_q    <= signed_op_i;
            rem_op_q    <= rem_op_i;
            div_zero_q  <= div_zero_i;
            same_sign_q <= same_sign_i;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - cnt_t'(1);         // Holds at zero when idle
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            rem_q      <= '0;
            quo_q      <= dividend_mag_i;       // Dividend bits shift out as quotient shifts in
            divisor_q  <= divisor_mag_i;
            dividend_q <= dividend_i;
            tag_q      <= tag_i;
        end else if (stepping) begin
            rem_q <= rem_next;
            quo_q <= quo_next;
        end
    end

    // ------------------------------------------------------------------
    // Sign and width correction
    // ------------------------------------------------------------------
    assign dividend_neg = op_32_q ? dividend_q[`DIV_WLEN-1] : dividend_q[`DIV_XLEN-1];

    always_comb begin
        // Quotient takes the XOR of the operand signs
        if (div_zero_q) begin
            quo_final = '1;
        end else if (signed_q & ~same_sign_q) begin
            quo_final = ~quo_q + xlen_t'(1);
        end else begin
            quo_final = quo_q;
        end

        // Remainder follows the dividend
        if (div_zero_q) begin
            rem_final = dividend_q;
        end else if (signed_q & dividend_neg) begin
            rem_final = ~rem_q + xlen_t'(1);
        end else begin
            rem_final = rem_q;
        end
    end

    assign sel      = rem_op_q ? rem_final : quo_final;
    assign sel_word = sel[`DIV_WLEN-1:0];

    // Word forms always sign-extend bit 31, unsigned ones too
    assign result_o = op_32_q ? {{(`DIV_XLEN-`DIV_WLEN){sel_word[`DIV_WLEN-1]}}, sel_word}
                              : sel;

    assign done_o = (cnt_q == cnt_t'(1));
    assign tag_o  = tag_q;

endmodule

// ==== div_unit/div_operand_prep.sv ====
// Combinational operand setup; word forms read only the low 32 bits and need XLEN == 2*WLEN
`include "div_cfg.svh"

module div_operand_prep (
    input  logic           op_32_i,
    input  logic           signed_op_i,
    input  div_pkg::xlen_t dividend_i,
    input  div_pkg::xlen_t divisor_i,
    output div_pkg::xlen_t dividend_mag_o,
    output div_pkg::xlen_t divisor_mag_o,
    output logic           div_zero_o,
    output logic           same_sign_o,
    output div_pkg::cnt_t  start_cnt_o
);

    import div_pkg::*;

    logic  dividend_sign;
    logic  divisor_sign;
    xlen_t dividend_abs;
    xlen_t divisor_abs;
    word_t dividend_word;
    word_t divisor_word;

    // ------------------------------------------------------------------
    // Sign bits and magnitudes
    // ------------------------------------------------------------------

    // Sign lives at bit 31 for word forms
    assign dividend_sign = op_32_i ? dividend_i[`DIV_WLEN-1] : dividend_i[`DIV_XLEN-1];
    assign divisor_sign  = op_32_i ? divisor_i[`DIV_WLEN-1]  : divisor_i[`DIV_XLEN-1];

    // Two's complement negate when signed and negative
    assign dividend_abs = (signed_op_i & dividend_sign) ? (~dividend_i + xlen_t'(1))
                                                        : dividend_i;
    assign divisor_abs  = (signed_op_i & divisor_sign)  ? (~divisor_i + xlen_t'(1))
                                                        : divisor_i;

    // Low word of the 64-bit negate equals the 32-bit negate
    assign dividend_word = dividend_abs[`DIV_WLEN-1:0];
    assign divisor_word  = divisor_abs[`DIV_WLEN-1:0];

    // ------------------------------------------------------------------
    // Alignment
    // ------------------------------------------------------------------

    // Word dividend goes on top so the shift steps consume it first
    assign dividend_mag_o = op_32_i ? {dividend_word, {`DIV_WLEN{1'b0}}} : dividend_abs;
    assign divisor_mag_o  = op_32_i ? {{(`DIV_XLEN-`DIV_WLEN){1'b0}}, divisor_word}
                                    : divisor_abs;

    // ------------------------------------------------------------------
    // Flags and cycle count
    // ------------------------------------------------------------------
    always_comb begin
        if (op_32_i) begin
            div_zero_o = (divisor_i[`DIV_WLEN-1:0] == '0);  // Upper half ignored
        end else begin
            div_zero_o = (divisor_i == '0);
        end
    end

    // Lane only uses this for signed operations
    assign same_sign_o = ~(dividend_sign ^ divisor_sign);

    assign start_cnt_o = op_32_i ? cnt_t'(`DIV_CNT_32) : cnt_t'(`DIV_CNT_64);

endmodule

// ==== div_unit/div_radix4_step.sv ====
// Two restoring steps per call; remainder must stay below the divisor on entry
`include "div_cfg.svh"

module div_radix4_step (
    input  div_pkg::xlen_t remainder_i,
    input  div_pkg::xlen_t quotient_i,   // Unconsumed dividend bits on top, quotient below
    input  div_pkg::xlen_t divisor_i,
    output div_pkg::xlen_t remainder_o,
    output div_pkg::xlen_t quotient_o
);

    import div_pkg::*;

    // ------------------------------------------------------------------
    // Shift-subtract chain
    // ------------------------------------------------------------------
    always_comb begin : steps
        logic [`DIV_XLEN:0] shifted;     // One extra bit, divisor may exceed 2^63
        xlen_t              rem;
        xlen_t              quo;

        rem = remainder_i;
        quo = quotient_i;
        for (int s = 0; s < `DIV_STEP_BITS; s++) begin
            // Next dividend bit moves into the partial remainder
            shifted = {rem, quo[`DIV_XLEN-1]};
            quo     = {quo[`DIV_XLEN-2:0], 1'b0};

            if (shifted >= {1'b0, divisor_i}) begin
                shifted = shifted - {1'b0, divisor_i};
                quo[0]  = 1'b1;                    // Quotient bit set
            end

            rem = shifted[`DIV_XLEN-1:0];          // Below divisor, fits again
        end

        remainder_o = rem;
        quotient_o  = quo;
    end

endmodule

// ==== common/div_pkg.sv ====
// Vector types sized from div_cfg.svh; the include path must reach common/
`include "div_cfg.svh"

package div_pkg;

    // ------------------------------------------------------------------
    // Datapath vectors
    // ------------------------------------------------------------------

    // Operands, remainder and quotient
    typedef logic [`DIV_XLEN-1:0] xlen_t;

    // Low half used by the word forms
    typedef logic [`DIV_WLEN-1:0] word_t;

    // ------------------------------------------------------------------
    // Control vectors
    // ------------------------------------------------------------------

    // Lane cycle counter, zero when idle
    typedef logic [`DIV_CNT_W-1:0] cnt_t;

    // Destination tag carried with each division
    typedef logic [`DIV_TAG_W-1:0] tag_t;

endpackage

// ==== common/div_cfg.svh ====
// Divider sizing for a 64-bit machine; operand width must be exactly twice the word width
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

// ----------------------------------------------------------------------
// Datapath widths
// ----------------------------------------------------------------------
`define DIV_XLEN      64    // Full operand width
`define DIV_WLEN      32    // Word operation width

// Quotient bits retired per clock by one lane
`define DIV_STEP_BITS 2

// ----------------------------------------------------------------------
// Lane counter
// ----------------------------------------------------------------------
`define DIV_CNT_W     6     // Holds the largest start count
`define DIV_CNT_64    33    // 32 steps plus the done cycle
`define DIV_CNT_32    17    // 16 steps plus the done cycle

`define DIV_TAG_W     5     // Destination register tag

`endif
